/* hw/flush_ctrl.sv */
// ====================
// Flush controller
// Registers the front-end redirect and the exception record
// when a redirecting or excepting entry retires
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module flush_ctrl (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire rob_pkg::retire_t retire,
  output rob_pkg::redirect_t    redirect,
  output rob_pkg::exc_rec_t     exc_rec
);

  typedef enum logic {
    IDLE  = 1'b0,
    ISSUE = 1'b1
  } state_e;

  state_e               state;
  state_e               state_nxt;
  logic                 hit;
  rob_pkg::rob_entry_t  hit_entry;
  logic [`PC_WIDTH-1:0] target_q;

  // Last retiring slot that stops the window
  always_comb begin
    hit       = 1'b0;
    hit_entry = '0;
    for (int i = 0; i < `RETIRE_WIDTH; i++) begin
      if (retire.valid[i] && (retire.entry[i].redirect || retire.entry[i].exception)) begin
        hit       = 1'b1;
        hit_entry = retire.entry[i];
      end
    end
  end

  always_comb begin
    case (state)
      IDLE:    state_nxt = hit ? ISSUE : IDLE;
      ISSUE:   state_nxt = hit ? ISSUE : IDLE;   // Back to back flush
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      exc_rec <= '0;
    end else begin
      state <= state_nxt;
      if (hit && hit_entry.exception) begin
        exc_rec.era   <= hit_entry.pc;
        exc_rec.ecode <= hit_entry.ecode;
        exc_rec.badv  <= hit_entry.bad_addr;
      end
    end
  end

  // Exception wins over a branch redirect on the same entry
  always_ff @(posedge clk) begin
    if (hit) begin
      target_q <= hit_entry.exception ? `EXC_VECTOR : hit_entry.br_target;
    end
  end

  assign redirect.valid  = (state == ISSUE);   // One cycle per flush
  assign redirect.target = target_q;

endmodule

`default_nettype wire

/* hw/isa_pkg.sv */
// ====================
// ISA encodings
// Instruction classes, memory operation kinds and exception codes
// as seen by the retirement back end
// ====================
`default_nettype none

package isa_pkg;

  // Execution class of an instruction
  typedef enum logic [1:0] {
    INST_ALU    = 2'd0,
    INST_BRANCH = 2'd1,
    INST_MEM    = 2'd2
  } inst_class_e;

  // Memory access kind with MEM_NONE outside the MEM class
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  typedef enum logic [1:0] {
    ECODE_NONE          = 2'd0,
    ECODE_ILLEGAL       = 2'd1,
    ECODE_ADDR_MISALIGN = 2'd2,
    ECODE_PAGE_FAULT    = 2'd3
  } ecode_e;

endpackage

`default_nettype wire

/* hw/retire_select.sv */
// ====================
// Retire selection
// Picks the in-order prefix of the head window that retires this
// cycle: completed entries, one branch, store only in slot 0,
// nothing after a redirect or exception
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module retire_select (
  input  wire rob_pkg::rob_entry_t [`RETIRE_WIDTH-1:0] window,
  output rob_pkg::retire_t                             retire,
  output logic [$clog2(`RETIRE_WIDTH):0]               retire_cnt,
  output logic                                         flush_now
);

  localparam int CNT_W = $clog2(`RETIRE_WIDTH) + 1;

  logic [`RETIRE_WIDTH-1:0] is_br;
  logic [`RETIRE_WIDTH-1:0] is_store;
  logic [`RETIRE_WIDTH-1:0] is_stop;      // Redirect or exception
  logic [`RETIRE_WIDTH-1:0] cmpl_mask;    // Completion chain
  logic [`RETIRE_WIDTH-1:0] stop_mask;
  logic [`RETIRE_WIDTH-1:0] seen_br;      // Older branch in window
  logic [`RETIRE_WIDTH-1:0] br_mask;
  logic [`RETIRE_WIDTH-1:0] st_mask;

  // ====================
  // Per-slot decode
  // ====================
  always_comb begin
    for (int i = 0; i < `RETIRE_WIDTH; i++) begin
      is_br[i]    = (window[i].inst_class == isa_pkg::INST_BRANCH);
      is_store[i] = (window[i].inst_class == isa_pkg::INST_MEM) &&
                    (window[i].mem_op == isa_pkg::MEM_STORE);
      is_stop[i]  = window[i].redirect | window[i].exception;
    end
  end

  // ====================
  // Prefix masks
  // ====================
  always_comb begin
    cmpl_mask[0] = window[0].complete;
    stop_mask[0] = 1'b1;
    seen_br[0]   = 1'b0;
    br_mask[0]   = 1'b1;
    st_mask[0]   = 1'b1;   // Slot 0 may hold a store
    for (int i = 1; i < `RETIRE_WIDTH; i++) begin
      cmpl_mask[i] = cmpl_mask[i-1] & window[i].complete;
      stop_mask[i] = stop_mask[i-1] & ~is_stop[i-1];
      seen_br[i]   = seen_br[i-1] | is_br[i-1];
      br_mask[i]   = br_mask[i-1] & ~(seen_br[i] & is_br[i]);
      st_mask[i]   = st_mask[i-1] & ~is_store[i];
    end
  end

  always_comb begin
    retire.valid = cmpl_mask & stop_mask & br_mask & st_mask;
    retire.entry = window;
    retire_cnt   = CNT_W'($countones(retire.valid));
    flush_now    = |(retire.valid & is_stop);   // Empties buffer at this edge
  end

endmodule

`default_nettype wire

/* hw/rob_consts.svh */
// ====================
// Reorder buffer constants
// Sizing of the buffer, the dispatch, writeback and retire widths,
// the pc width and the exception vector
// ====================
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// Buffer geometry
`define ROB_DEPTH       16
`define ROB_IDX_W       $clog2(`ROB_DEPTH)

// Lanes per cycle
`define DISPATCH_WIDTH  2
`define WB_WIDTH        2
`define RETIRE_WIDTH    2

`define PC_WIDTH        32
`define EXC_VECTOR      32'h0000_1c00  // Trap entry for every exception

`endif

/* hw/rob_pkg.sv */
// ====================
// Reorder buffer types
// Entry layout and the allocate, writeback, retire,
// redirect and exception record bundles
// ====================
`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

  // One buffer slot
  typedef struct packed {
    logic [`PC_WIDTH-1:0]  pc;
    isa_pkg::inst_class_e  inst_class;
    isa_pkg::mem_op_e      mem_op;
    logic                  complete;   // Written back
    logic                  redirect;   // Branch mispredicted
    logic                  exception;
    isa_pkg::ecode_e       ecode;
    logic [`PC_WIDTH-1:0]  br_target;
    logic [`PC_WIDTH-1:0]  bad_addr;
  } rob_entry_t;

  // Dispatch side with valid lanes packed from lane 0
  typedef struct packed {
    logic [`DISPATCH_WIDTH-1:0]                valid;
    logic [`DISPATCH_WIDTH-1:0][`PC_WIDTH-1:0] pc;
    isa_pkg::inst_class_e [`DISPATCH_WIDTH-1:0] inst_class;
    isa_pkg::mem_op_e [`DISPATCH_WIDTH-1:0]    mem_op;
  } alloc_req_t;

  typedef struct packed {
    logic                                       ready;
    logic [`DISPATCH_WIDTH-1:0][`ROB_IDX_W-1:0] rob_idx;
  } alloc_rsp_t;

  // One writeback port as a single-cycle strobe
  typedef struct packed {
    logic                  valid;
    logic [`ROB_IDX_W-1:0] rob_idx;
    logic                  redirect;
    logic [`PC_WIDTH-1:0]  br_target;
    logic                  exception;
    isa_pkg::ecode_e       ecode;
    logic [`PC_WIDTH-1:0]  bad_addr;
  } wb_req_t;

  typedef struct packed {
    logic [`RETIRE_WIDTH-1:0]  valid;
    rob_entry_t [`RETIRE_WIDTH-1:0] entry;
  } retire_t;

  // Front-end redirect
  typedef struct packed {
    logic                 valid;
    logic [`PC_WIDTH-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [`PC_WIDTH-1:0] era;    // Pc of the faulting entry
    isa_pkg::ecode_e      ecode;
    logic [`PC_WIDTH-1:0] badv;
  } exc_rec_t;

endpackage

`default_nettype wire

/* hw/rob_storage.sv */
// ====================
// Reorder buffer storage
// Entry array with wrap-bit head and tail pointers and occupancy count.
// Allocates up to two entries per cycle, merges writebacks and
// presents the entries at the head to the retire logic
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_storage (
  input  wire logic                                   clk,
  input  wire logic                                   rst_n,
  input  wire logic                                   flush,
  input  wire logic                                   flush_now,
  input  wire rob_pkg::alloc_req_t                    alloc_req,
  output rob_pkg::alloc_rsp_t                         alloc_rsp,
  input  wire rob_pkg::wb_req_t [`WB_WIDTH-1:0]       wb_req,
  input  wire logic [$clog2(`RETIRE_WIDTH):0]         retire_cnt,
  output rob_pkg::rob_entry_t [`RETIRE_WIDTH-1:0]     window
);

  localparam int PTR_W   = `ROB_IDX_W + 1;            // Index plus wrap bit
  localparam int ALLOC_W = $clog2(`DISPATCH_WIDTH) + 1;

  // ====================
  // State
  // ====================
  rob_pkg::rob_entry_t entries [`ROB_DEPTH];

  logic [PTR_W-1:0] head_ptr;
  logic [PTR_W-1:0] tail_ptr;
  logic [PTR_W-1:0] count;

  logic                   clear;        // Buffer empties at this edge
  logic [ALLOC_W-1:0]     alloc_cnt;
  logic [ALLOC_W-1:0]     take_cnt;     // Lanes actually accepted
  logic [`ROB_IDX_W-1:0]  win_idx [`RETIRE_WIDTH];
  rob_pkg::rob_entry_t    new_entry [`DISPATCH_WIDTH];

  assign clear = flush | flush_now;

  // ====================
  // Allocation
  // ====================
  always_comb begin
    alloc_cnt       = ALLOC_W'($countones(alloc_req.valid));
    alloc_rsp.ready = (count <= PTR_W'(`ROB_DEPTH - `DISPATCH_WIDTH));
    take_cnt        = alloc_rsp.ready ? alloc_cnt : '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      alloc_rsp.rob_idx[i] = tail_ptr[`ROB_IDX_W-1:0] + `ROB_IDX_W'(i);
      new_entry[i]            = '0;            // Complete and flags clear
      new_entry[i].pc         = alloc_req.pc[i];
      new_entry[i].inst_class = alloc_req.inst_class[i];
      new_entry[i].mem_op     = alloc_req.mem_op[i];
    end
  end

  // Entry array with allocation and writeback merge
  always_ff @(posedge clk) begin
    if (!clear && alloc_rsp.ready) begin
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        if (alloc_req.valid[i]) begin
          entries[alloc_rsp.rob_idx[i]] <= new_entry[i];
        end
      end
    end
    for (int p = 0; p < `WB_WIDTH; p++) begin
      if (wb_req[p].valid) begin
        entries[wb_req[p].rob_idx].complete  <= 1'b1;
        entries[wb_req[p].rob_idx].redirect  <= wb_req[p].redirect;
        entries[wb_req[p].rob_idx].br_target <= wb_req[p].br_target;
        entries[wb_req[p].rob_idx].exception <= wb_req[p].exception;
        entries[wb_req[p].rob_idx].ecode     <= wb_req[p].ecode;
        entries[wb_req[p].rob_idx].bad_addr  <= wb_req[p].bad_addr;
      end
    end
  end

  // ====================
  // Pointers and count
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
    end else if (clear) begin
      head_ptr <= '0;   // Pending allocations dropped too
      tail_ptr <= '0;
      count    <= '0;
    end else begin
      head_ptr <= head_ptr + PTR_W'(retire_cnt);
      tail_ptr <= tail_ptr + PTR_W'(take_cnt);
      count    <= count + PTR_W'(take_cnt) - PTR_W'(retire_cnt);
    end
  end

  // Head window where slots past the count read as empty
  always_comb begin
    for (int i = 0; i < `RETIRE_WIDTH; i++) begin
      win_idx[i] = head_ptr[`ROB_IDX_W-1:0] + `ROB_IDX_W'(i);
      if (PTR_W'(i) < count) begin
        window[i] = entries[win_idx[i]];
      end else begin
        window[i] = '0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/rob_top.sv */
// ====================
// Reorder buffer top
// Storage, retire selection and flush control
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_top (
  input  wire logic                             clk,
  input  wire logic                             rst_n,
  input  wire logic                             flush,
  input  wire rob_pkg::alloc_req_t              alloc_req,
  output rob_pkg::alloc_rsp_t                   alloc_rsp,
  input  wire rob_pkg::wb_req_t [`WB_WIDTH-1:0] wb_req,
  output rob_pkg::retire_t                      retire,
  output rob_pkg::redirect_t                    redirect,
  output rob_pkg::exc_rec_t                     exc_rec
);

  rob_pkg::rob_entry_t [`RETIRE_WIDTH-1:0] window;
  logic [$clog2(`RETIRE_WIDTH):0]          retire_cnt;
  logic                                    flush_now;

  rob_storage u_rob_storage (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush      (flush),
    .flush_now  (flush_now),
    .alloc_req  (alloc_req),
    .alloc_rsp  (alloc_rsp),
    .wb_req     (wb_req),
    .retire_cnt (retire_cnt),
    .window     (window)
  );

  retire_select u_retire_select (
    .window     (window),
    .retire     (retire),
    .retire_cnt (retire_cnt),
    .flush_now  (flush_now)
  );

  flush_ctrl u_flush_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .retire   (retire),
    .redirect (redirect),
    .exc_rec  (exc_rec)
  );

endmodule

`default_nettype wire

/* rob_top.f */
+incdir+hw
+incdir+test
hw/isa_pkg.sv
hw/rob_pkg.sv
hw/rob_storage.sv
hw/retire_select.sv
hw/flush_ctrl.sv
hw/rob_top.sv
test/tb_rob_top.sv

/* test/rob_model.svh */
// ====================
// Reorder buffer reference model
// In-order queue of allocated entries, the retire rules,
// the stimulus LFSR and the compare task
// ====================
`ifndef ROB_MODEL_SVH
`define ROB_MODEL_SVH

rob_pkg::rob_entry_t m_ent [`ROB_DEPTH];   // Indexed by rob index
int                  m_q [$];              // Rob indices from oldest to youngest
int                  m_tail = 0;
logic [31:0]         lfsr = 32'h884a_9a06;
int                  n_checks = 0;
int                  n_errors = 0;

logic                 exp_redir_valid = 1'b0;
logic [`PC_WIDTH-1:0] exp_redir_target = '0;
rob_pkg::exc_rec_t    exp_exc = '0;

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r    = {r[30:0], lfsr[0]};
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
  end
  return r;
endfunction

task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
  n_checks++;
  if (exp !== act) begin
    n_errors++;
    $display("[ERROR] %s at %0t ns: expected %0h, actual %0h", name, $time, exp, act);
  end
endtask

// Walk from the oldest entry until a rule blocks
task automatic predict_retire(output logic [`RETIRE_WIDTH-1:0] rv, output logic stop);
  rob_pkg::rob_entry_t e;
  int                  brs;
  rv   = '0;
  stop = 1'b0;
  brs  = 0;
  for (int i = 0; i < `RETIRE_WIDTH; i++) begin
    if (i >= m_q.size() || stop) break;
    e = m_ent[m_q[i]];
    if (!e.complete) break;
    if (e.inst_class == isa_pkg::INST_BRANCH && brs > 0) break;
    if (e.mem_op == isa_pkg::MEM_STORE && i != 0) break;   // Store only from slot 0
    if (e.inst_class == isa_pkg::INST_BRANCH) begin
      brs++;
    end
    rv[i] = 1'b1;
    stop  = e.redirect | e.exception;
  end
endtask

// Apply one clock edge: retire, writeback, allocate or clear
task automatic model_edge(input logic [`RETIRE_WIDTH-1:0] rv, input logic stop,
                          input logic ext_flush, input rob_pkg::alloc_req_t req,
                          input rob_pkg::wb_req_t [`WB_WIDTH-1:0] wb);
  rob_pkg::rob_entry_t e;
  int                  nret;
  int                  dummy;
  logic                ready;
  nret  = $countones(rv);
  ready = (m_q.size() <= `ROB_DEPTH - `DISPATCH_WIDTH);   // From count before the edge
  exp_redir_valid = stop;
  if (stop) begin
    e = m_ent[m_q[nret-1]];
    exp_redir_target = e.exception ? `EXC_VECTOR : e.br_target;
    if (e.exception) begin
      exp_exc.era   = e.pc;
      exp_exc.ecode = e.ecode;
      exp_exc.badv  = e.bad_addr;
    end
  end
  for (int p = 0; p < `WB_WIDTH; p++) begin
    if (wb[p].valid) begin
      e           = m_ent[wb[p].rob_idx];
      e.complete  = 1'b1;
      e.redirect  = wb[p].redirect;
      e.br_target = wb[p].br_target;
      e.exception = wb[p].exception;
      e.ecode     = wb[p].ecode;
      e.bad_addr  = wb[p].bad_addr;
      m_ent[wb[p].rob_idx] = e;
    end
  end
  if (stop || ext_flush) begin
    m_q.delete();   // Same-cycle allocations are lost
    m_tail = 0;
  end else begin
    repeat (nret) begin
      dummy = m_q.pop_front();
    end
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (ready && req.valid[i]) begin
        e            = '0;
        e.pc         = req.pc[i];
        e.inst_class = req.inst_class[i];
        e.mem_op     = req.mem_op[i];
        m_ent[m_tail] = e;
        m_q.push_back(m_tail);
        m_tail = (m_tail + 1) % `ROB_DEPTH;
      end
    end
  end
endtask

`endif

/* test/tb_rob_top.sv */
// ====================
// Reorder buffer testbench
// Random allocation, writeback and flush traffic, checked
// cycle by cycle against a reference model
// ====================
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module tb_rob_top;

  localparam int NUM_CYCLES   = 4000;
  localparam int PERIOD_NS    = 4;
  localparam int RESET_CYCLES = 10;
  localparam int TIMEOUT_NS   = (NUM_CYCLES + RESET_CYCLES + 100) * PERIOD_NS;
  localparam int IDX_W        = $clog2(`ROB_DEPTH);

  logic                             clk;
  logic                             rst_n;
  logic                             flush;
  rob_pkg::alloc_req_t              alloc_req;
  rob_pkg::alloc_rsp_t              alloc_rsp;
  rob_pkg::wb_req_t [`WB_WIDTH-1:0] wb_req;
  rob_pkg::retire_t                 retire;
  rob_pkg::redirect_t               redirect;
  rob_pkg::exc_rec_t                exc_rec;

  int wb_hold = 0;   // Cycles left with writebacks held back

  `include "rob_model.svh"

  rob_top u_rob_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .alloc_req (alloc_req),
    .alloc_rsp (alloc_rsp),
    .wb_req    (wb_req),
    .retire    (retire),
    .redirect  (redirect),
    .exc_rec   (exc_rec)
  );

  always #(PERIOD_NS / 2) clk = ~clk;

  // ====================
  // Output checks
  // ====================
  task automatic compare_outputs(output logic [`RETIRE_WIDTH-1:0] rv, output logic stop);
    logic exp_ready;
    int   nbr;
    int   nst;
    predict_retire(rv, stop);
    exp_ready = (m_q.size() <= `ROB_DEPTH - `DISPATCH_WIDTH);
    check("alloc_ready", 128'(exp_ready), 128'(alloc_rsp.ready));
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (alloc_req.valid[i]) begin
        check("alloc_idx", 128'((m_tail + i) % `ROB_DEPTH), 128'(alloc_rsp.rob_idx[i]));
      end
    end
    check("retire_valid", 128'(rv), 128'(retire.valid));
    nbr = 0;
    nst = 0;
    for (int i = 0; i < `RETIRE_WIDTH; i++) begin
      if (rv[i]) begin
        check("retire_entry", 128'(m_ent[m_q[i]]), 128'(retire.entry[i]));
      end
      if (retire.valid[i] && retire.entry[i].inst_class == isa_pkg::INST_BRANCH) begin
        nbr++;
      end
      if (i > 0 && retire.valid[i] && retire.entry[i].mem_op == isa_pkg::MEM_STORE) begin
        nst++;
      end
    end
    check("retire_branch_limit", 128'(0), 128'(nbr > 1));
    check("retire_store_slot", 128'(0), 128'(nst));
    check("redirect_valid", 128'(exp_redir_valid), 128'(redirect.valid));
    if (exp_redir_valid) begin
      check("redirect_target", 128'(exp_redir_target), 128'(redirect.target));
    end
    check("exc_rec", 128'(exp_exc), 128'(exc_rec));
  endtask

  // ====================
  // Stimulus
  // ====================
  task automatic drive_stimulus();
    rob_pkg::alloc_req_t              req;
    rob_pkg::wb_req_t [`WB_WIDTH-1:0] wb;
    int                               cand [$];
    int                               nlanes;
    int                               pick;
    logic [1:0]                       cls;
    logic [1:0]                       ec;
    req    = '0;
    wb     = '0;
    nlanes = int'(rand_bits(2));
    if (nlanes > `DISPATCH_WIDTH) begin
      nlanes = `DISPATCH_WIDTH;
    end
    for (int i = 0; i < nlanes; i++) begin   // Lanes packed from 0
      cls          = 2'(rand_bits(2));
      req.valid[i] = 1'b1;
      req.pc[i]    = rand_bits(30) << 2;
      case (cls)
        2'd1: req.inst_class[i] = isa_pkg::INST_BRANCH;
        2'd2: begin
          req.inst_class[i] = isa_pkg::INST_MEM;
          req.mem_op[i]     = rand_bits(1) ? isa_pkg::MEM_STORE : isa_pkg::MEM_LOAD;
        end
        default: req.inst_class[i] = isa_pkg::INST_ALU;
      endcase
    end
    if (wb_hold > 0) begin
      wb_hold--;
    end else if (rand_bits(6) == 0) begin   // Stall completions so the buffer fills up
      wb_hold = 16 + int'(rand_bits(3));
    end
    foreach (m_q[k]) begin
      if (!m_ent[m_q[k]].complete) begin
        cand.push_back(m_q[k]);
      end
    end
    for (int p = 0; p < `WB_WIDTH; p++) begin
      if (wb_hold == 0 && cand.size() > 0 && rand_bits(2) != 0) begin
        pick          = int'(rand_bits(4)) % cand.size();
        wb[p].valid   = 1'b1;
        wb[p].rob_idx = IDX_W'(cand[pick]);
        cand.delete(pick);
        if (m_ent[wb[p].rob_idx].inst_class == isa_pkg::INST_BRANCH && rand_bits(3) == 0) begin
          wb[p].redirect  = 1'b1;
          wb[p].br_target = rand_bits(30) << 2;
        end
        if (rand_bits(5) == 0) begin   // Rare fault
          ec = 2'(rand_bits(2));
          if (ec == 2'd0) begin
            ec = 2'd1;
          end
          wb[p].exception = 1'b1;
          wb[p].ecode     = isa_pkg::ecode_e'(ec);
          wb[p].bad_addr  = rand_bits(32);
        end
      end
    end
    alloc_req <= req;
    wb_req    <= wb;
    flush     <= (rand_bits(6) == 0);
  endtask

  // Sample, advance the model, then drive the next cycle
  always @(posedge clk) begin : cycle_blk
    logic [`RETIRE_WIDTH-1:0] exp_valid;
    logic                     exp_stop;
    if (rst_n) begin
      compare_outputs(exp_valid, exp_stop);
      model_edge(exp_valid, exp_stop, flush, alloc_req, wb_req);
      drive_stimulus();
    end
  end

  // ====================
  // Run control
  // ====================
  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    flush     = 1'b0;
    alloc_req = '0;
    wb_req    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (NUM_CYCLES) @(posedge clk);
    @(negedge clk);
    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
